/* Makefile */
# Verilator flow for the dataflow slice testbench

VERILATOR ?= verilator
TOP       ?= dn_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+hdl
hdl/dn_route_pkg.sv
hdl/dn_data_pkg.sv
hdl/dn_link_if.sv
hdl/distribute_switch.sv
hdl/mult_lane.sv
hdl/reduce_adder.sv
hdl/dn_top.sv
verification/dn_asserts.sv
verification/dn_tb.sv

/* hdl/distribute_switch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dn_settings.svh"

module distribute_switch
(
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   i_valid,
	input  wire dn_route_pkg::dn_cmd_e i_cmd,
	input  wire dn_data_pkg::dn_word_t i_word,
	output logic                  o_credit,
	dn_link_if.sender             lo,
	dn_link_if.sender             hi
);
	import dn_route_pkg::*;
	import dn_data_pkg::*;

	localparam int IN_PTR_W = $clog2(`DN_IN_DEPTH);
	localparam int IN_CNT_W = $clog2(`DN_IN_DEPTH + 1);
	localparam int LN_CNT_W = $clog2(`DN_LANE_DEPTH + 1);

	// input buffer, command kept beside its word
	dn_cmd_e             cmd_mem [`DN_IN_DEPTH];
	dn_word_t            word_mem [`DN_IN_DEPTH];
	logic [IN_PTR_W-1:0] wr_ptr;
	logic [IN_PTR_W-1:0] rd_ptr;
	logic [IN_CNT_W-1:0] fill;

	// credits toward each lane FIFO
	logic [LN_CNT_W-1:0] lo_cnt;
	logic [LN_CNT_W-1:0] hi_cnt;

	// head decode
	dn_cmd_e             head_cmd;
	dn_word_t            head_word;
	logic                need_lo;
	logic                need_hi;
	logic                head_go;

	//////////////////////////////////////////////////////////////////////
	// input buffer
	//////////////////////////////////////////////////////////////////////

	// no overflow check, upstream credits bound the fill
	always_ff @(posedge clk)
	begin
		if (i_valid)
		begin
			cmd_mem[wr_ptr]  <= i_cmd;
			word_mem[wr_ptr] <= i_word;
		end
	end

	assign head_cmd  = cmd_mem[rd_ptr];
	assign head_word = word_mem[rd_ptr];

	// bit 0 low lane, bit 1 high lane
	assign need_lo = (head_cmd == DN_LOW) || (head_cmd == DN_BOTH);
	assign need_hi = (head_cmd == DN_HIGH) || (head_cmd == DN_BOTH);

	// drop words need no credit, a duplicate needs both
	assign head_go = (fill != '0)
		&& (!need_lo || (lo_cnt != '0))
		&& (!need_hi || (hi_cnt != '0));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fill     <= '0;
			o_credit <= 1'b0;
		end
		else
		begin
			if (i_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (head_go)
				rd_ptr <= rd_ptr + 1'b1;
			fill     <= fill + IN_CNT_W'(i_valid) - IN_CNT_W'(head_go);
			// entry freed on this edge, give it back upstream
			o_credit <= head_go;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// lane side
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lo.valid <= 1'b0;
			hi.valid <= 1'b0;
			lo_cnt   <= LN_CNT_W'(`DN_LANE_DEPTH);
			hi_cnt   <= LN_CNT_W'(`DN_LANE_DEPTH);
		end
		else
		begin
			lo.valid <= head_go && need_lo;
			hi.valid <= head_go && need_hi;
			// spend on send, refill on each returned pulse
			lo_cnt   <= lo_cnt - LN_CNT_W'(head_go && need_lo) + LN_CNT_W'(lo.credit);
			hi_cnt   <= hi_cnt - LN_CNT_W'(head_go && need_hi) + LN_CNT_W'(hi.credit);
		end
	end

	// same word on both links, tagged when duplicated
	always_ff @(posedge clk)
	begin
		if (head_go)
		begin
			lo.data   <= head_word;
			hi.data   <= head_word;
			lo.joined <= (head_cmd == DN_BOTH) ? DN_TAG_JOINED : DN_TAG_SINGLE;
			hi.joined <= (head_cmd == DN_BOTH) ? DN_TAG_JOINED : DN_TAG_SINGLE;
		end
	end

endmodule

`default_nettype wire

/* hdl/dn_data_pkg.sv */
`default_nettype none

`include "dn_settings.svh"

package dn_data_pkg;

	// activation or configuration
	typedef enum logic {
		DN_ACT = 1'b0,
		DN_CFG = 1'b1
	} dn_kind_e;

	// configuration view, weight in the upper bits
	typedef struct packed {
		logic signed [`DN_WGT_W-1:0] weight;
		logic        [`DN_SHIFT_W-1:0] shift;
	} dn_cfg_t;

	// one payload word, read through the view its kind selects
	typedef union packed {
		logic signed [`DN_DATA_W-1:0] act;
		dn_cfg_t                      cfg;
	} dn_payload_u;

	// word as it travels from the input to a lane
	typedef struct packed {
		dn_kind_e    kind;
		dn_payload_u payload;
	} dn_word_t;

	// result word types
	typedef logic signed [`DN_RES_W-1:0] dn_res_t;

	typedef struct packed {
		dn_res_t prod;
		logic    joined;
	} dn_lane_res_t;

endpackage

`default_nettype wire

/* hdl/dn_link_if.sv */
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// credit-controlled link
//////////////////////////////////////////////////////////////////////

interface dn_link_if #(
	parameter type T = logic
);
	import dn_route_pkg::*;

	// forward path, sender owned
	logic    valid;
	T        data;
	dn_tag_e joined;

	// one-cycle pulse per freed receiver entry
	logic    credit;

	modport sender (
		output valid,
		output data,
		output joined,
		input  credit
	);

	modport receiver (
		input  valid,
		input  data,
		input  joined,
		output credit
	);

endinterface

`default_nettype wire

/* hdl/dn_route_pkg.sv */
`default_nettype none

package dn_route_pkg;

	// route command of the distribute switch
	// bit 0 selects the low lane, bit 1 the high lane
	typedef enum logic [1:0] {
		DN_DROP = 2'b00,
		DN_LOW  = 2'b01,
		DN_HIGH = 2'b10,
		DN_BOTH = 2'b11
	} dn_cmd_e;

	// result source, same code points as the command
	// 2'b00 never leaves the adder
	typedef enum logic [1:0] {
		DN_SRC_LOW  = 2'b01,
		DN_SRC_HIGH = 2'b10,
		DN_SRC_BOTH = 2'b11
	} dn_src_e;

	// link tag marks a word that was duplicated to both lanes
	typedef enum logic {
		DN_TAG_SINGLE = 1'b0,
		DN_TAG_JOINED = 1'b1
	} dn_tag_e;

endpackage

`default_nettype wire

/* hdl/dn_settings.svh */
`ifndef DN_SETTINGS_SVH
`define DN_SETTINGS_SVH

// activation and payload width
`define DN_DATA_W 16
// configuration view of the payload, weight then shift
`define DN_WGT_W 12
`define DN_SHIFT_W 4
// lane product and reduced sum width
`define DN_RES_W 32

// buffer entries equal the starting credit of each link
// all depths kept at powers of two so pointers wrap on their own
`define DN_IN_DEPTH 2
`define DN_LANE_DEPTH 4
`define DN_RED_DEPTH 2

`endif

/* hdl/dn_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dn_settings.svh"

module dn_top
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          i_valid,
	input  wire dn_route_pkg::dn_cmd_e   i_cmd,
	input  wire dn_data_pkg::dn_word_t   i_word,
	output wire                          o_credit,
	output wire                          o_res_valid,
	output wire signed [`DN_RES_W-1:0]   o_res_data,
	output wire dn_route_pkg::dn_src_e   o_res_src
);
	import dn_data_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// internal links
	//////////////////////////////////////////////////////////////////////

	// switch to lanes
	dn_link_if #(.T(dn_word_t)) lo_word_if ();
	dn_link_if #(.T(dn_word_t)) hi_word_if ();

	// lanes to adder
	dn_link_if #(.T(dn_lane_res_t)) lo_res_if ();
	dn_link_if #(.T(dn_lane_res_t)) hi_res_if ();

	distribute_switch u_switch (
		.clk      (clk),
		.rst      (rst),
		.i_valid  (i_valid),
		.i_cmd    (i_cmd),
		.i_word   (i_word),
		.o_credit (o_credit),
		.lo       (lo_word_if.sender),
		.hi       (hi_word_if.sender)
	);

	// two identical lanes side by side
	mult_lane u_lane_lo (
		.clk (clk),
		.rst (rst),
		.rx  (lo_word_if.receiver),
		.tx  (lo_res_if.sender)
	);

	mult_lane u_lane_hi (
		.clk (clk),
		.rst (rst),
		.rx  (hi_word_if.receiver),
		.tx  (hi_res_if.sender)
	);

	reduce_adder u_adder (
		.clk         (clk),
		.rst         (rst),
		.lo          (lo_res_if.receiver),
		.hi          (hi_res_if.receiver),
		.o_res_valid (o_res_valid),
		.o_res_data  (o_res_data),
		.o_res_src   (o_res_src)
	);

endmodule

`default_nettype wire

/* hdl/mult_lane.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dn_settings.svh"

module mult_lane
(
	input  wire         clk,
	input  wire         rst,
	dn_link_if.receiver rx,
	dn_link_if.sender   tx
);
	import dn_route_pkg::*;
	import dn_data_pkg::*;

	localparam int PTR_W     = $clog2(`DN_LANE_DEPTH);
	localparam int CNT_W     = $clog2(`DN_LANE_DEPTH + 1);
	localparam int RES_CNT_W = $clog2(`DN_RED_DEPTH + 1);

	// lane FIFO, tag stored beside the word
	dn_word_t                    word_mem [`DN_LANE_DEPTH];
	dn_tag_e                     tag_mem [`DN_LANE_DEPTH];
	logic [PTR_W-1:0]            wr_ptr;
	logic [PTR_W-1:0]            rd_ptr;
	logic [CNT_W-1:0]            fill;

	// credits toward the adder buffer
	logic [RES_CNT_W-1:0]        res_cnt;

	// scaling state
	logic signed [`DN_WGT_W-1:0] weight_q;
	logic [`DN_SHIFT_W-1:0]      shift_q;

	dn_word_t                    head;
	dn_tag_e                     head_tag;
	logic                        pop_cfg;
	logic                        pop_act;
	dn_res_t                     act_ext;
	dn_res_t                     wgt_ext;
	dn_res_t                     scaled;

	always_ff @(posedge clk)
	begin
		if (rx.valid)
		begin
			word_mem[wr_ptr] <= rx.data;
			tag_mem[wr_ptr]  <= rx.joined;
		end
	end

	assign head     = word_mem[rd_ptr];
	assign head_tag = tag_mem[rd_ptr];

	// config words never wait, activations need room in the adder
	assign pop_cfg = (fill != '0) && (head.kind == DN_CFG);
	assign pop_act = (fill != '0) && (head.kind == DN_ACT) && (res_cnt != '0);

	// signed extend both operands, then arithmetic shift
	assign act_ext = head.payload.act;
	assign wgt_ext = weight_q;
	assign scaled  = (act_ext * wgt_ext) >>> shift_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			fill      <= '0;
			res_cnt   <= RES_CNT_W'(`DN_RED_DEPTH);
			rx.credit <= 1'b0;
			tx.valid  <= 1'b0;
			weight_q  <= '0;
			shift_q   <= '0;
		end
		else
		begin
			if (rx.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_cfg || pop_act)
				rd_ptr <= rd_ptr + 1'b1;
			fill      <= fill + CNT_W'(rx.valid) - CNT_W'(pop_cfg || pop_act);
			rx.credit <= pop_cfg || pop_act;
			tx.valid  <= pop_act;
			res_cnt   <= res_cnt - RES_CNT_W'(pop_act) + RES_CNT_W'(tx.credit);
			// configuration view of the same payload
			if (pop_cfg)
			begin
				weight_q <= head.payload.cfg.weight;
				shift_q  <= head.payload.cfg.shift;
			end
		end
	end

	// result register, joined flag rides along
	always_ff @(posedge clk)
	begin
		if (pop_act)
		begin
			tx.data.prod   <= scaled;
			tx.data.joined <= (head_tag == DN_TAG_JOINED);
			tx.joined      <= head_tag;
		end
	end

endmodule

`default_nettype wire

/* hdl/reduce_adder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dn_settings.svh"

module reduce_adder
(
	input  wire                          clk,
	input  wire                          rst,
	dn_link_if.receiver                  lo,
	dn_link_if.receiver                  hi,
	output logic                         o_res_valid,
	output logic signed [`DN_RES_W-1:0]  o_res_data,
	output dn_route_pkg::dn_src_e        o_res_src
);
	import dn_route_pkg::*;
	import dn_data_pkg::*;

	localparam int PTR_W = $clog2(`DN_RED_DEPTH);
	localparam int CNT_W = $clog2(`DN_RED_DEPTH + 1);

	// index 0 low lane, index 1 high lane
	dn_lane_res_t     buf_mem [2][`DN_RED_DEPTH];
	logic [PTR_W-1:0] wr_ptr [2];
	logic [PTR_W-1:0] rd_ptr [2];
	logic [CNT_W-1:0] fill [2];

	logic [1:0]       in_valid;
	dn_lane_res_t     in_data [2];
	dn_lane_res_t     head [2];
	logic [1:0]       has;
	logic [1:0]       pop;
	logic             take_both;
	logic             take_lo;
	logic             take_hi;

	assign in_valid = {hi.valid, lo.valid};
	assign in_data[0] = lo.data;
	assign in_data[1] = hi.data;

	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			head[i] = buf_mem[i][rd_ptr[i]];
			has[i]  = (fill[i] != '0);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// join and priority
	//////////////////////////////////////////////////////////////////////

	// joined pair first, then low single, then high single
	assign take_both = has[0] && has[1] && head[0].joined && head[1].joined;
	assign take_lo   = !take_both && has[0] && !head[0].joined;
	assign take_hi   = !take_both && !take_lo && has[1] && !head[1].joined;

	assign pop[0] = take_both || take_lo;
	assign pop[1] = take_both || take_hi;

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (in_valid[i])
				buf_mem[i][wr_ptr[i]] <= in_data[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 2; i++)
			begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				fill[i]   <= '0;
			end
			lo.credit   <= 1'b0;
			hi.credit   <= 1'b0;
			o_res_valid <= 1'b0;
			o_res_src   <= DN_SRC_LOW;
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (in_valid[i])
					wr_ptr[i] <= wr_ptr[i] + 1'b1;
				if (pop[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				fill[i] <= fill[i] + CNT_W'(in_valid[i]) - CNT_W'(pop[i]);
			end
			// every popped entry goes back to its lane
			lo.credit   <= pop[0];
			hi.credit   <= pop[1];
			o_res_valid <= take_both || take_lo || take_hi;
			if (take_both)
				o_res_src <= DN_SRC_BOTH;
			else if (take_lo)
				o_res_src <= DN_SRC_LOW;
			else if (take_hi)
				o_res_src <= DN_SRC_HIGH;
		end
	end

	// sum wraps at result width
	always_ff @(posedge clk)
	begin
		if (take_both)
			o_res_data <= head[0].prod + head[1].prod;
		else if (take_lo)
			o_res_data <= head[0].prod;
		else if (take_hi)
			o_res_data <= head[1].prod;
	end

endmodule

`default_nettype wire

/* verification/dn_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dn_settings.svh"

module dn_asserts #(
	parameter int CNT_W   = 3,
	parameter int CNT_MAX = 4,
	parameter bit HAS_SRC = 1'b1
)
(
	input wire                        clk,
	input wire                        rst,
	input wire [CNT_W-1:0]            i_cnt_lo,
	input wire [CNT_W-1:0]            i_cnt_hi,
	input wire                        i_out_valid,
	input wire dn_route_pkg::dn_src_e i_src
);
	import dn_route_pkg::*;

	// a count that wrapped below zero lands above the max too
	a_lo_range: assert property (@(posedge clk) disable iff (rst) i_cnt_lo <= CNT_W'(CNT_MAX))
		else $error("low count %0d above %0d", i_cnt_lo, CNT_MAX);

	a_hi_range: assert property (@(posedge clk) disable iff (rst) i_cnt_hi <= CNT_W'(CNT_MAX))
		else $error("high count %0d above %0d", i_cnt_hi, CNT_MAX);

	// outputs quiet right after a reset edge
	a_reset_quiet: assert property (@(posedge clk) rst |=> !i_out_valid)
		else $error("output valid in the cycle after reset");

	// only a block with a result port carries a source
	if (HAS_SRC)
	begin : g_src
		a_src_code: assert property (@(posedge clk) disable iff (rst) 2'(i_src) != 2'(DN_DROP))
			else $error("result source carries the drop code");
	end

endmodule

//////////////////////////////////////////////////////////////////////
// bindings
//////////////////////////////////////////////////////////////////////

// switch lane credit counters and its upstream credit pulse
// the switch has no result source to check
bind distribute_switch dn_asserts #(
	.CNT_W   ($clog2(`DN_LANE_DEPTH + 1)),
	.CNT_MAX (`DN_LANE_DEPTH),
	.HAS_SRC (1'b0)
) u_switch_asserts (
	.clk         (clk),
	.rst         (rst),
	.i_cnt_lo    (lo_cnt),
	.i_cnt_hi    (hi_cnt),
	.i_out_valid (o_credit),
	.i_src       (dn_route_pkg::DN_SRC_BOTH)
);

// adder per-lane buffer fill and its result port
bind reduce_adder dn_asserts #(
	.CNT_W   ($clog2(`DN_RED_DEPTH + 1)),
	.CNT_MAX (`DN_RED_DEPTH),
	.HAS_SRC (1'b1)
) u_adder_asserts (
	.clk         (clk),
	.rst         (rst),
	.i_cnt_lo    (fill[0]),
	.i_cnt_hi    (fill[1]),
	.i_out_valid (o_res_valid),
	.i_src       (o_res_src)
);

`default_nettype wire

/* verification/dn_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dn_settings.svh"

module dn_tb;
	import dn_route_pkg::*;
	import dn_data_pkg::*;

	localparam int WAIT_LIMIT  = 100;
	localparam int DRAIN_LIMIT = 2000;

	logic     clk;
	logic     rst;
	logic     i_valid;
	dn_cmd_e  i_cmd;
	dn_word_t i_word;
	logic     o_credit;
	logic     o_res_valid;
	dn_res_t  o_res_data;
	dn_src_e  o_res_src;

	// run bookkeeping
	logic [15:0] lfsr_q;
	string       cur_test;
	int          errors;
	int          test_err0;
	int          n_tests;
	int          n_failed;
	int          sent_cnt;
	int          credit_ret;

	// reference model, index 0 low, 1 high, 2 both
	logic signed [`DN_WGT_W-1:0] wgt_m [2];
	int                          shf_m [2];
	dn_res_t                     exp_lo [$];
	dn_res_t                     exp_hi [$];
	dn_res_t                     exp_both [$];
	int                          want [3];
	int                          got [3];
	dn_src_e                     last_src;

	dn_top dut (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (i_valid),
		.i_cmd       (i_cmd),
		.i_word      (i_word),
		.o_credit    (o_credit),
		.o_res_valid (o_res_valid),
		.o_res_data  (o_res_data),
		.o_res_src   (o_res_src)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// random source and word builders
	//////////////////////////////////////////////////////////////////////

	// galois form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	// one step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_step(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic dn_word_t make_act(input logic signed [`DN_DATA_W-1:0] a);
		dn_word_t w;
		w.kind        = DN_ACT;
		w.payload.act = a;
		return w;
	endfunction

	function automatic dn_word_t make_cfg(input logic signed [`DN_WGT_W-1:0] wt,
		input logic [`DN_SHIFT_W-1:0] sh);
		dn_word_t w;
		w.kind               = DN_CFG;
		w.payload.cfg.weight = wt;
		w.payload.cfg.shift  = sh;
		return w;
	endfunction

	function automatic dn_word_t make_word(input logic is_cfg);
		logic [31:0] r;
		r = rand_bits(`DN_DATA_W);
		if (is_cfg)
			return make_cfg(r[15:4], r[3:0]);
		return make_act(r[15:0]);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// activation times weight, then arithmetic shift right, kept to 32 bits
	function automatic dn_res_t lane_product(input logic signed [`DN_DATA_W-1:0] act,
		input logic signed [`DN_WGT_W-1:0] wt, input int sh);
		longint p;
		p = longint'(act) * longint'(wt);
		p = p >>> sh;
		return dn_res_t'(p);
	endfunction

	task automatic model_word(input dn_cmd_e cmd, input dn_word_t w);
		logic    to_lo;
		logic    to_hi;
		dn_res_t p_lo;
		dn_res_t p_hi;
		to_lo = (cmd == DN_LOW) || (cmd == DN_BOTH);
		to_hi = (cmd == DN_HIGH) || (cmd == DN_BOTH);
		if (w.kind == DN_CFG)
		begin
			// config lands in every lane the command names
			if (to_lo)
			begin
				wgt_m[0] = w.payload.cfg.weight;
				shf_m[0] = int'(w.payload.cfg.shift);
			end
			if (to_hi)
			begin
				wgt_m[1] = w.payload.cfg.weight;
				shf_m[1] = int'(w.payload.cfg.shift);
			end
		end
		else
		begin
			p_lo = lane_product(w.payload.act, wgt_m[0], shf_m[0]);
			p_hi = lane_product(w.payload.act, wgt_m[1], shf_m[1]);
			if (cmd == DN_BOTH)
			begin
				// sum wraps at result width
				exp_both.push_back(p_lo + p_hi);
				want[2]++;
			end
			else if (cmd == DN_LOW)
			begin
				exp_lo.push_back(p_lo);
				want[0]++;
			end
			else if (cmd == DN_HIGH)
			begin
				exp_hi.push_back(p_hi);
				want[1]++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_res(input string what, input dn_res_t exp, input dn_res_t act);
		if (exp !== act)
		begin
			$display("FAILED %s expected %0d actual %0d", what, exp, act);
			errors++;
		end
	endtask

	task automatic check_src(input string what, input dn_src_e exp, input dn_src_e act);
		if (exp !== act)
		begin
			$display("FAILED %s expected %s actual %s", what, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (exp != act)
		begin
			$display("FAILED %s expected %0d actual %0d", what, exp, act);
			errors++;
		end
	endtask

	task automatic unexpected(input string lane);
		$display("%s: %s result arrived with nothing expected", cur_test, lane);
		errors++;
	endtask

	// head of the queue the source names
	task automatic take_result(input dn_src_e src, input dn_res_t data);
		last_src = src;
		case (src)
			DN_SRC_LOW:
			begin
				got[0]++;
				if (exp_lo.size() == 0)
					unexpected("low");
				else
					check_res({cur_test, " low result"}, exp_lo.pop_front(), data);
			end
			DN_SRC_HIGH:
			begin
				got[1]++;
				if (exp_hi.size() == 0)
					unexpected("high");
				else
					check_res({cur_test, " high result"}, exp_hi.pop_front(), data);
			end
			DN_SRC_BOTH:
			begin
				got[2]++;
				if (exp_both.size() == 0)
					unexpected("joined");
				else
					check_res({cur_test, " joined result"}, exp_both.pop_front(), data);
			end
			default:
			begin
				$display("%s: result carried an undefined source code", cur_test);
				errors++;
			end
		endcase
	endtask

	function automatic int credits_left();
		return `DN_IN_DEPTH + credit_ret - sent_cnt;
	endfunction

	// credit and result monitor, reads registered outputs before the edge
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (o_credit)
			begin
				credit_ret++;
				if (credits_left() > `DN_IN_DEPTH)
				begin
					$display("%s: a credit came back for a word never sent", cur_test);
					errors++;
				end
			end
			if (o_res_valid)
				take_result(o_res_src, o_res_data);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// driver
	//////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic idle(input int n);
		i_valid = 1'b0;
		repeat (n)
			step();
	endtask

	task automatic give_up(input string what);
		$display("%s: timed out waiting for %s", cur_test, what);
		$display("tests failed");
		$finish;
	endtask

	task automatic wait_credit();
		int n;
		n = 0;
		while ((credits_left() <= 0) && (n < WAIT_LIMIT))
		begin
			i_valid = 1'b0;
			step();
			n++;
		end
		if (credits_left() <= 0)
			give_up("an input credit");
	endtask

	// valid stays high across back to back sends
	task automatic send(input dn_cmd_e cmd, input dn_word_t w);
		wait_credit();
		model_word(cmd, w);
		i_valid = 1'b1;
		i_cmd   = cmd;
		i_word  = w;
		sent_cnt++;
		step();
		i_valid = 1'b0;
	endtask

	// all expected results out and every input credit home
	task automatic drain();
		int n;
		n = 0;
		i_valid = 1'b0;
		while (((exp_lo.size() + exp_hi.size() + exp_both.size()) != 0
			|| credits_left() != `DN_IN_DEPTH) && (n < DRAIN_LIMIT))
		begin
			step();
			n++;
		end
		if (n >= DRAIN_LIMIT)
			give_up("results to drain");
		// room for any stray result
		idle(10);
	endtask

	task automatic check_counts();
		check_count({cur_test, " low count"}, want[0], got[0]);
		check_count({cur_test, " high count"}, want[1], got[1]);
		check_count({cur_test, " joined count"}, want[2], got[2]);
		check_count({cur_test, " pending"}, 0, exp_lo.size() + exp_hi.size() + exp_both.size());
		check_count({cur_test, " credits home"}, `DN_IN_DEPTH, credits_left());
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_err0 = errors;
		for (int i = 0; i < 3; i++)
		begin
			want[i] = 0;
			got[i]  = 0;
		end
	endtask

	task automatic end_test();
		n_tests++;
		if (errors == test_err0)
			$display("test %s: ok", cur_test);
		else
		begin
			$display("test %s: %0d errors", cur_test, errors - test_err0);
			n_failed++;
		end
	endtask

	// config then eight activations through one lane
	task automatic run_single(input string name, input dn_cmd_e cmd, input dn_src_e src);
		logic [31:0] r;
		begin_test(name);
		r = rand_bits(16);
		send(cmd, make_cfg(r[15:4], r[3:0]));
		for (int k = 0; k < 8; k++)
		begin
			r = rand_bits(16);
			send(cmd, make_act(r[15:0]));
		end
		drain();
		check_counts();
		check_src({cur_test, " source"}, src, last_src);
		end_test();
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0]                 r;
		logic signed [`DN_WGT_W-1:0] wl;
		logic signed [`DN_WGT_W-1:0] wh;

		rst        = 1'b1;
		i_valid    = 1'b0;
		i_cmd      = DN_DROP;
		i_word     = '0;
		lfsr_q     = 16'd62;
		errors     = 0;
		n_tests    = 0;
		n_failed   = 0;
		sent_cnt   = 0;
		credit_ret = 0;
		last_src   = DN_SRC_LOW;
		cur_test   = "reset";
		for (int i = 0; i < 2; i++)
		begin
			wgt_m[i] = '0;
			shf_m[i] = 0;
		end
		repeat (4)
			@(posedge clk);
		#2;
		rst = 1'b0;

		// quiet after reset, then spend the whole input credit at once
		begin_test("reset_idle");
		idle(20);
		check_count({cur_test, " results"}, 0, got[0] + got[1] + got[2]);
		check_count({cur_test, " credits"}, `DN_IN_DEPTH, credits_left());
		repeat (`DN_IN_DEPTH)
			send(DN_DROP, make_act(16'sd0));
		check_count({cur_test, " credits after burst"}, 0, credits_left());
		drain();
		check_counts();
		end_test();

		run_single("low_lane", DN_LOW, DN_SRC_LOW);
		run_single("high_lane", DN_HIGH, DN_SRC_HIGH);

		begin_test("both_lanes");
		r  = rand_bits(16);
		wl = r[15:4];
		send(DN_LOW, make_cfg(wl, r[3:0]));
		r  = rand_bits(16);
		wh = r[15:4];
		// distinct weights so a swapped lane shows up
		if (wh == wl)
			wh = ~wl;
		send(DN_HIGH, make_cfg(wh, r[3:0]));
		for (int k = 0; k < 8; k++)
		begin
			r = rand_bits(16);
			send(DN_BOTH, make_act(r[15:0]));
		end
		drain();
		check_counts();
		check_src({cur_test, " source"}, DN_SRC_BOTH, last_src);
		end_test();

		// a quarter config words, short idle gaps
		begin_test("random_mix");
		for (int k = 0; k < 300; k++)
		begin
			r = rand_bits(4);
			send(dn_cmd_e'(r[3:2]), make_word(r[1:0] == 2'b00));
			r = rand_bits(2);
			idle(int'(r[1:0]));
		end
		drain();
		check_counts();
		end_test();

		begin_test("full_credit_bursts");
		for (int b = 0; b < 4; b++)
		begin
			drain();
			for (int k = 0; k < 50; k++)
			begin
				r = rand_bits(4);
				send(dn_cmd_e'(r[3:2]), make_word(r[1:0] == 2'b00));
			end
		end
		drain();
		check_counts();
		end_test();

		$display("tests run %0d, passed %0d, failed %0d", n_tests, n_tests - n_failed, n_failed);
		if ((n_failed == 0) && (errors == 0))
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
